// File: files.f
src/axis_switch_pkg.sv
src/skid_buffer.sv
src/axil_switch_regs.sv
src/packet_switch_core.sv
src/axis_switch_top.sv
testbench/tb_axis_switch.sv

// File: Makefile
# Verilator build and run of the AXI-Stream packet switch testbench

VERILATOR ?= verilator
TOP       ?= tb_axis_switch
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS EXTRA"

build:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No pass line found in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_axis_switch.sv
// Testbench of the AXI-Stream packet switch with AXI4-Lite control, checked by assertions
module tb_axis_switch;
	timeunit 1ns;
	timeprecision 1ps;
	import axis_switch_pkg::*;

	// Well above the expected run length
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic prev_rst_n = 1'b0;
	int   seed = 7595;
	int   errors = 0;
	int   cyc = 0;
	int   out_beats = 0;

	// AXI4-Lite side
	logic                       awvalid = 1'b0, wvalid = 1'b0, bready = 1'b1;
	logic                       arvalid = 1'b0, rready = 1'b1;
	logic [AXIL_ADDR_WIDTH-1:0] awaddr = '0, araddr = '0;
	logic [AXIL_DATA_WIDTH-1:0] wdata = '0;
	logic [AXIL_STRB_WIDTH-1:0] wstrb = '0;
	logic                       awready, wready, bvalid, arready, rvalid;
	logic [1:0]                 bresp, rresp;
	logic [AXIL_DATA_WIDTH-1:0] rdata;

	// Stream side
	logic [NUM_STREAMS-1:0]                 s_tvalid = '0;
	logic [NUM_STREAMS-1:0]                 s_tlast = '0;
	logic [NUM_STREAMS*AXIS_DATA_WIDTH-1:0] s_tdata = '0;
	logic [NUM_STREAMS-1:0]                 s_tready;
	logic                                   m_tvalid, m_tlast;
	logic                                   m_tready = 1'b0;
	logic [AXIS_DATA_WIDTH-1:0]             m_tdata;

	// Reference state
	logic [LG_STREAMS-1:0]      sel_model = '0;
	logic                       src_run = 1'b0;
	logic                       hold_req = 1'b0;
	logic                       sink_stuck = 1'b0;
	logic [NUM_STREAMS-1:0]     src_hs = '0;
	int                         beat_idx [NUM_STREAMS] = '{default: 0};
	int                         pkt_len [NUM_STREAMS] = '{default: 3};
	int                         pkt_cnt [NUM_STREAMS] = '{default: 0};
	// Scoreboard rings per stream
	logic [AXIS_DATA_WIDTH-1:0] sb_data [NUM_STREAMS][256];
	logic                       sb_last [NUM_STREAMS][256];
	logic [7:0]                 sb_wr [NUM_STREAMS] = '{default: '0};
	logic [7:0]                 sb_rd [NUM_STREAMS] = '{default: '0};
	logic [LG_STREAMS-1:0]      stream_id, out_id, pkt_stream = '0;
	logic                       out_hs, out_last, pkt_open = 1'b0;
	logic [AXIS_DATA_WIDTH-1:0] exp_head;
	logic                       exp_last;
	logic                       exp_have;
	// Previous-edge copies for hold and latency checks
	logic                       prev_tvalid = 1'b0, prev_tready = 1'b0, prev_tlast = 1'b0;
	logic [AXIS_DATA_WIDTH-1:0] prev_tdata = '0;
	logic                       prev_ar_hs = 1'b0;
	// Expected read data under a mask
	logic                       rd_check = 1'b0;
	logic [AXIL_DATA_WIDTH-1:0] rd_exp = '0, rd_mask = '0;

	axis_switch_top dut (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rst_n),
		.i_s_axi_awvalid(awvalid), .o_s_axi_awready(awready),
		.i_s_axi_awaddr(awaddr), .i_s_axi_awprot(3'b000),
		.i_s_axi_wvalid(wvalid), .o_s_axi_wready(wready),
		.i_s_axi_wdata(wdata), .i_s_axi_wstrb(wstrb),
		.o_s_axi_bvalid(bvalid), .i_s_axi_bready(bready), .o_s_axi_bresp(bresp),
		.i_s_axi_arvalid(arvalid), .o_s_axi_arready(arready),
		.i_s_axi_araddr(araddr), .i_s_axi_arprot(3'b000),
		.o_s_axi_rvalid(rvalid), .i_s_axi_rready(rready),
		.o_s_axi_rdata(rdata), .o_s_axi_rresp(rresp),
		.i_s_axis_tvalid(s_tvalid), .o_s_axis_tready(s_tready),
		.i_s_axis_tdata(s_tdata), .i_s_axis_tlast(s_tlast),
		.o_m_axis_tvalid(m_tvalid), .i_m_axis_tready(m_tready),
		.o_m_axis_tdata(m_tdata), .o_m_axis_tlast(m_tlast));

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Stream sources and sink
	////////////////////////////////////////////////////////////

	// Beat word holds the stream, a packet count and a beat count
	for (genvar gs = 0; gs < NUM_STREAMS; gs++)
	begin : g_src
		always @(posedge clk)
		begin
			src_hs[gs] = s_tvalid[gs] && s_tready[gs];
			#2;
			if (src_hs[gs])
			begin
				sb_data[gs][sb_wr[gs]] = s_tdata[gs*AXIS_DATA_WIDTH +: AXIS_DATA_WIDTH];
				sb_last[gs][sb_wr[gs]] = s_tlast[gs];
				sb_wr[gs] = sb_wr[gs] + 8'd1;
				s_tvalid[gs] = 1'b0;
				if (s_tlast[gs])
				begin
					beat_idx[gs] = 0;
					pkt_cnt[gs]++;
					pkt_len[gs] = 1 + int'(($random(seed) & 32'hff) % 6);
				end
				else
					beat_idx[gs]++;
			end
			// Random gaps, and an open packet still finishes after the stop
			if (rst_n && !s_tvalid[gs] && (src_run || beat_idx[gs] != 0)
				&& (($random(seed) & 3) != 0))
			begin
				s_tvalid[gs] = 1'b1;
				s_tdata[gs*AXIS_DATA_WIDTH +: AXIS_DATA_WIDTH] =
					{8'(gs), 12'(pkt_cnt[gs]), 12'(beat_idx[gs])};
				s_tlast[gs] = (beat_idx[gs] == pkt_len[gs] - 1);
			end
		end
	end

	// Expected head for the stream named in the output beat
	assign stream_id = m_tdata[AXIS_DATA_WIDTH-7 -: LG_STREAMS];
	assign exp_head  = sb_data[stream_id][sb_rd[stream_id]];
	assign exp_last  = sb_last[stream_id][sb_rd[stream_id]];
	assign exp_have  = (sb_rd[stream_id] != sb_wr[stream_id]);

	always @(posedge clk)
	begin
		out_hs = m_tvalid && m_tready;
		out_last = m_tlast;
		out_id = stream_id;
		#2;
		if (out_hs)
		begin
			sb_rd[out_id] = sb_rd[out_id] + 8'd1;
			out_beats++;
			if (!pkt_open)
				pkt_stream = out_id;
			pkt_open = !out_last;
		end
		// Freeze on an open packet when asked to
		if (hold_req && (sink_stuck || (m_tvalid && !m_tlast)))
		begin
			m_tready = 1'b0;
			sink_stuck = 1'b1;
		end
		else
		begin
			sink_stuck = 1'b0;
			m_tready = (($random(seed) & 3) != 0);
		end
	end

	always @(posedge clk)
	begin
		prev_rst_n <= rst_n;
		prev_tvalid <= m_tvalid;
		prev_tready <= m_tready;
		prev_tdata <= m_tdata;
		prev_tlast <= m_tlast;
		prev_ar_hs <= arvalid && arready;
		cyc <= cyc + 1;
	end

	always @(posedge clk)
	begin
		if (cyc >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run stopped after %0d cycles, %0d errors", cyc, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	a_reset: assert property (@(posedge clk)
		(cyc >= 1 && (!rst_n || !prev_rst_n)) |-> (!m_tvalid && !bvalid && !rvalid))
	else
	begin
		errors++;
		$display("CHECK FAILED: o_m_axis_tvalid/o_s_axi_bvalid/o_s_axi_rvalid expected 0 got %h %h %h",
			m_tvalid, bvalid, rvalid);
	end

	a_bresp: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bresp == 2'b00)
	else
	begin
		errors++;
		$display("CHECK FAILED: o_s_axi_bresp expected 0 got %h", bresp);
	end

	a_rresp: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rresp == 2'b00)
	else
	begin
		errors++;
		$display("CHECK FAILED: o_s_axi_rresp expected 0 got %h", rresp);
	end

	a_rlat: assert property (@(posedge clk) disable iff (!rst_n) prev_ar_hs |-> rvalid)
	else
	begin
		errors++;
		$display("CHECK FAILED: o_s_axi_rvalid expected 1 got %h", rvalid);
	end

	a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && rready && rd_check) |-> ((rdata & rd_mask) == rd_exp))
	else
	begin
		errors++;
		$display("CHECK FAILED: o_s_axi_rdata expected %h got %h (mask %h)", rd_exp,
			rdata & rd_mask, rd_mask);
	end

	a_order: assert property (@(posedge clk) disable iff (!rst_n)
		(m_tvalid && m_tready)
		|-> (exp_have && m_tdata == exp_head && m_tlast == exp_last))
	else
	begin
		errors++;
		$display("CHECK FAILED: o_m_axis_tdata/tlast expected %h %h got %h %h (pending %h)",
			exp_head, exp_last, m_tdata, m_tlast, exp_have);
	end

	a_packet: assert property (@(posedge clk) disable iff (!rst_n)
		(m_tvalid && m_tready && pkt_open) |-> stream_id == pkt_stream)
	else
	begin
		errors++;
		$display("CHECK FAILED: o_m_axis_tdata stream expected %h got %h", pkt_stream,
			stream_id);
	end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(prev_tvalid && !prev_tready)
		|-> (m_tvalid && m_tdata == prev_tdata && m_tlast == prev_tlast))
	else
	begin
		errors++;
		$display("CHECK FAILED: o_m_axis_tdata/tlast held %h %h got %h %h valid %h",
			prev_tdata, prev_tlast, m_tdata, m_tlast, m_tvalid);
	end

	////////////////////////////////////////////////////////////
	// AXI4-Lite tasks
	////////////////////////////////////////////////////////////

	task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
		input logic [AXIL_DATA_WIDTH-1:0] data, input logic [AXIL_STRB_WIDTH-1:0] strb);
		logic                       aw_done;
		logic                       w_done;
		logic [AXIL_DATA_WIDTH-1:0] merged;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge clk);
		#2;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		while (!(aw_done && w_done))
		begin
			@(posedge clk);
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			#2;
			if (aw_done)
				awvalid = 1'b0;
			if (w_done)
				wvalid = 1'b0;
		end
		do
			@(posedge clk);
		while (!bvalid);
		// Select keeps the low bits of the strobed merge
		if (addr[AXIL_ADDR_WIDTH-1:ADDR_LSB] == REG_SELECT)
		begin
			merged = {{(AXIL_DATA_WIDTH-LG_STREAMS){1'b0}}, sel_model};
			for (int b = 0; b < AXIL_STRB_WIDTH; b++)
			begin
				if (strb[b])
					merged[b*8 +: 8] = data[b*8 +: 8];
			end
			sel_model = merged[LG_STREAMS-1:0];
		end
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
		input logic [AXIL_DATA_WIDTH-1:0] exp, input logic [AXIL_DATA_WIDTH-1:0] mask);
		logic ar_done;
		ar_done = 1'b0;
		@(posedge clk);
		#2;
		rd_exp = exp;
		rd_mask = mask;
		rd_check = 1'b1;
		arvalid = 1'b1;
		araddr = addr;
		while (!ar_done)
		begin
			@(posedge clk);
			ar_done = arvalid && arready;
			#2;
			if (ar_done)
				arvalid = 1'b0;
		end
		do
			@(posedge clk);
		while (!rvalid);
		#2;
		rd_check = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		axil_read(3'h0, 32'h0, 32'hffff_ffff);

		// Full strobes first, then bit 0 clear and a status write
		axil_write(3'h0, 32'hffff_fff2, 4'hf);
		axil_read(3'h0, {30'b0, sel_model}, 32'hffff_ffff);
		axil_write(3'h0, 32'h0000_0001, 4'b1110);
		axil_read(3'h0, {30'b0, sel_model}, 32'hffff_ffff);
		axil_write(3'h4, 32'h0000_0003, 4'hf);
		axil_read(3'h0, {30'b0, sel_model}, 32'hffff_ffff);
		axil_write(3'h0, 32'h0, 4'hf);

		// Traffic with select changes landing mid-packet
		src_run = 1'b1;
		for (int r = 0; r < 14; r++)
		begin
			repeat (20 + int'($random(seed) & 31)) @(posedge clk);
			axil_write(3'h0, {30'b0, 2'($random(seed))}, 4'hf);
		end

		// Open packet held at the output
		repeat (30) @(posedge clk);
		hold_req = 1'b1;
		do
			@(posedge clk);
		while (!sink_stuck);
		axil_read(3'h4, 32'h1 << STATUS_BUSY_BIT, 32'h1 << STATUS_BUSY_BIT);
		hold_req = 1'b0;

		// Active source drained before the boundary status read
		src_run = 1'b0;
		do
			@(posedge clk);
		while (m_tvalid || s_tvalid[sel_model] || beat_idx[sel_model] != 0
			|| sb_rd[sel_model] != sb_wr[sel_model]);
		axil_read(3'h4, {30'b0, sel_model}, 32'hffff_ffff);

		if (out_beats < 40)
		begin
			errors++;
			$display("Too few output beats seen: %0d", out_beats);
		end
		$display("Run finished after %0d cycles, %0d output beats, %0d errors", cyc,
			out_beats, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: src/axis_switch_top.sv
// AXI4-Lite controlled AXI-Stream packet switch, register block and switch core joined
module axis_switch_top (
	input  logic                                        S_AXI_ACLK,
	input  logic                                        S_AXI_ARESETN,

	// AXI4-Lite control
	input  logic                                        i_s_axi_awvalid,
	output logic                                        o_s_axi_awready,
	input  logic [axis_switch_pkg::AXIL_ADDR_WIDTH-1:0] i_s_axi_awaddr,
	input  logic [2:0]                                  i_s_axi_awprot,
	input  logic                                        i_s_axi_wvalid,
	output logic                                        o_s_axi_wready,
	input  logic [axis_switch_pkg::AXIL_DATA_WIDTH-1:0] i_s_axi_wdata,
	input  logic [axis_switch_pkg::AXIL_STRB_WIDTH-1:0] i_s_axi_wstrb,
	output logic                                        o_s_axi_bvalid,
	input  logic                                        i_s_axi_bready,
	output logic [1:0]                                  o_s_axi_bresp,
	input  logic                                        i_s_axi_arvalid,
	output logic                                        o_s_axi_arready,
	input  logic [axis_switch_pkg::AXIL_ADDR_WIDTH-1:0] i_s_axi_araddr,
	input  logic [2:0]                                  i_s_axi_arprot,
	output logic                                        o_s_axi_rvalid,
	input  logic                                        i_s_axi_rready,
	output logic [axis_switch_pkg::AXIL_DATA_WIDTH-1:0] o_s_axi_rdata,
	output logic [1:0]                                  o_s_axi_rresp,

	// Input streams
	input  logic [axis_switch_pkg::NUM_STREAMS-1:0]     i_s_axis_tvalid,
	output logic [axis_switch_pkg::NUM_STREAMS-1:0]     o_s_axis_tready,
	input  logic [axis_switch_pkg::NUM_STREAMS*axis_switch_pkg::AXIS_DATA_WIDTH-1:0]
	                                                    i_s_axis_tdata,
	input  logic [axis_switch_pkg::NUM_STREAMS-1:0]     i_s_axis_tlast,

	// Output stream
	output logic                                        o_m_axis_tvalid,
	input  logic                                        i_m_axis_tready,
	output logic [axis_switch_pkg::AXIS_DATA_WIDTH-1:0] o_m_axis_tdata,
	output logic                                        o_m_axis_tlast
);
	import axis_switch_pkg::*;

	// Register block to core
	logic [LG_STREAMS-1:0] req_index;
	// Core back to register block
	logic [LG_STREAMS-1:0] active_index;
	logic                  mid_packet;

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////
	axil_switch_regs u_regs (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(i_s_axi_awvalid), .o_awready(o_s_axi_awready),
		.i_awaddr(i_s_axi_awaddr), .i_awprot(i_s_axi_awprot),
		.i_wvalid(i_s_axi_wvalid), .o_wready(o_s_axi_wready),
		.i_wdata(i_s_axi_wdata), .i_wstrb(i_s_axi_wstrb),
		.o_bvalid(o_s_axi_bvalid), .i_bready(i_s_axi_bready), .o_bresp(o_s_axi_bresp),
		.i_arvalid(i_s_axi_arvalid), .o_arready(o_s_axi_arready),
		.i_araddr(i_s_axi_araddr), .i_arprot(i_s_axi_arprot),
		.o_rvalid(o_s_axi_rvalid), .i_rready(i_s_axi_rready),
		.o_rdata(o_s_axi_rdata), .o_rresp(o_s_axi_rresp),
		.i_active_index(active_index), .i_mid_packet(mid_packet),
		.o_req_index(req_index));

	////////////////////////////////////////////////////////////
	// Stream switch
	////////////////////////////////////////////////////////////
	packet_switch_core u_core (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_req_index(req_index),
		.i_s_tvalid(i_s_axis_tvalid), .o_s_tready(o_s_axis_tready),
		.i_s_tdata(i_s_axis_tdata), .i_s_tlast(i_s_axis_tlast),
		.o_m_tvalid(o_m_axis_tvalid), .i_m_tready(i_m_axis_tready),
		.o_m_tdata(o_m_axis_tdata), .o_m_tlast(o_m_axis_tlast),
		.o_active_index(active_index), .o_mid_packet(mid_packet));

endmodule

// File: src/packet_switch_core.sv
// Packet-boundary stream selector with input skid buffers and a registered output
module packet_switch_core (
	input  logic                                        S_AXI_ACLK,
	input  logic                                        S_AXI_ARESETN,

	// Source requested by software
	input  logic [axis_switch_pkg::LG_STREAMS-1:0]      i_req_index,

	// Input streams, packed by stream number
	input  logic [axis_switch_pkg::NUM_STREAMS-1:0]     i_s_tvalid,
	output logic [axis_switch_pkg::NUM_STREAMS-1:0]     o_s_tready,
	input  logic [axis_switch_pkg::NUM_STREAMS*axis_switch_pkg::AXIS_DATA_WIDTH-1:0]
	                                                    i_s_tdata,
	input  logic [axis_switch_pkg::NUM_STREAMS-1:0]     i_s_tlast,

	// Output stream
	output logic                                        o_m_tvalid,
	input  logic                                        i_m_tready,
	output logic [axis_switch_pkg::AXIS_DATA_WIDTH-1:0] o_m_tdata,
	output logic                                        o_m_tlast,

	// Status toward the register block
	output logic [axis_switch_pkg::LG_STREAMS-1:0]      o_active_index,
	output logic                                        o_mid_packet
);
	import axis_switch_pkg::*;

	logic [NUM_STREAMS-1:0]     skd_valid;
	logic [NUM_STREAMS-1:0]     skd_last;
	logic [NUM_STREAMS-1:0]     skd_ready;
	logic [AXIS_DATA_WIDTH-1:0] skd_data [NUM_STREAMS];
	// Packet state after the last output beat left
	logic                       r_mid_packet;
	logic                       mid_packet;
	logic                       index_pending;

	////////////////////////////////////////////////////////////
	// Input skid buffers
	////////////////////////////////////////////////////////////

	// Unselected inputs take one beat, then stall
	for (genvar gk = 0; gk < NUM_STREAMS; gk++)
	begin : g_input
		skid_buffer #(.DW(AXIS_DATA_WIDTH + 1)) u_skid (
			.i_clk(S_AXI_ACLK), .i_reset(S_AXI_ARESETN),
			.i_valid(i_s_tvalid[gk]), .o_ready(o_s_tready[gk]),
			.i_data({i_s_tdata[gk*AXIS_DATA_WIDTH +: AXIS_DATA_WIDTH], i_s_tlast[gk]}),
			.o_valid(skd_valid[gk]), .i_ready(skd_ready[gk]),
			.o_data({skd_data[gk], skd_last[gk]}));
	end

	////////////////////////////////////////////////////////////
	// Packet tracking and source select
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_mid_packet <= 1'b0;
		else if (o_m_tvalid)
			r_mid_packet <= !o_m_tlast;
	end

	// Beat in the output register decides, else the remembered state
	assign mid_packet   = o_m_tvalid ? !o_m_tlast : r_mid_packet;
	assign o_mid_packet = mid_packet;

	// Boundary reached and a new source is waiting
	assign index_pending = !mid_packet && (i_req_index != o_active_index);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_active_index <= '0;
		else if (!mid_packet)
			o_active_index <= i_req_index;
	end

	// One-hot ready, blocked by back-pressure or a pending switch
	always_comb
	begin
		skd_ready = NUM_STREAMS'(1) << o_active_index;
		if (o_m_tvalid && !i_m_tready)
			skd_ready = '0;
		if (index_pending)
			skd_ready = '0;
	end

	////////////////////////////////////////////////////////////
	// Registered output stage
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_tvalid <= 1'b0;
		else if (!o_m_tvalid || i_m_tready)
			o_m_tvalid <= |(skd_valid & skd_ready);
	end

	// Payload loads with the valid, content only matters when valid
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_m_tvalid || i_m_tready)
		begin
			o_m_tdata <= skd_data[o_active_index];
			o_m_tlast <= skd_last[o_active_index];
		end
	end

endmodule

// File: src/axil_switch_regs.sv
// AXI4-Lite slave holding the source select register and reporting switch status
module axil_switch_regs (
	input  logic                                         S_AXI_ACLK,
	input  logic                                         S_AXI_ARESETN,

	// Write address
	input  logic                                         i_awvalid,
	output logic                                         o_awready,
	input  logic [axis_switch_pkg::AXIL_ADDR_WIDTH-1:0]  i_awaddr,
	input  logic [2:0]                                   i_awprot,

	// Write data
	input  logic                                         i_wvalid,
	output logic                                         o_wready,
	input  logic [axis_switch_pkg::AXIL_DATA_WIDTH-1:0]  i_wdata,
	input  logic [axis_switch_pkg::AXIL_STRB_WIDTH-1:0]  i_wstrb,

	// Write response
	output logic                                         o_bvalid,
	input  logic                                         i_bready,
	output logic [1:0]                                   o_bresp,

	// Read address
	input  logic                                         i_arvalid,
	output logic                                         o_arready,
	input  logic [axis_switch_pkg::AXIL_ADDR_WIDTH-1:0]  i_araddr,
	input  logic [2:0]                                   i_arprot,

	// Read data
	output logic                                         o_rvalid,
	input  logic                                         i_rready,
	output logic [axis_switch_pkg::AXIL_DATA_WIDTH-1:0]  o_rdata,
	output logic [1:0]                                   o_rresp,

	// Switch core side
	input  logic [axis_switch_pkg::LG_STREAMS-1:0]       i_active_index,
	input  logic                                         i_mid_packet,
	output logic [axis_switch_pkg::LG_STREAMS-1:0]       o_req_index
);
	import axis_switch_pkg::*;

	localparam int WADDR_W = AXIL_ADDR_WIDTH - ADDR_LSB;

	logic                       awskd_valid;
	logic [WADDR_W-1:0]         awskd_addr;
	logic                       wskd_valid;
	logic [AXIL_DATA_WIDTH-1:0] wskd_data;
	logic [AXIL_STRB_WIDTH-1:0] wskd_strb;
	logic                       arskd_valid;
	logic [WADDR_W-1:0]         arskd_addr;
	logic                       write_ready;
	logic                       read_ready;
	logic [AXIL_DATA_WIDTH-1:0] merged_word;
	logic [AXIL_DATA_WIDTH-1:0] read_word;

	// Byte lanes with strobe set take new data
	function automatic logic [AXIL_DATA_WIDTH-1:0] apply_wstrb(
		input logic [AXIL_DATA_WIDTH-1:0] prior,
		input logic [AXIL_DATA_WIDTH-1:0] value,
		input logic [AXIL_STRB_WIDTH-1:0] strb
	);
		logic [AXIL_DATA_WIDTH-1:0] merged;
		merged = prior;
		for (int k = 0; k < AXIL_STRB_WIDTH; k++)
		begin
			if (strb[k])
				merged[k*8 +: 8] = value[k*8 +: 8];
		end
		return merged;
	endfunction

	////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////

	// Only the word address is kept
	skid_buffer #(.DW(WADDR_W)) u_aw_skid (
		.i_clk(S_AXI_ACLK), .i_reset(S_AXI_ARESETN),
		.i_valid(i_awvalid), .o_ready(o_awready),
		.i_data(i_awaddr[AXIL_ADDR_WIDTH-1:ADDR_LSB]),
		.o_valid(awskd_valid), .i_ready(write_ready), .o_data(awskd_addr));

	skid_buffer #(.DW(AXIL_DATA_WIDTH + AXIL_STRB_WIDTH)) u_w_skid (
		.i_clk(S_AXI_ACLK), .i_reset(S_AXI_ARESETN),
		.i_valid(i_wvalid), .o_ready(o_wready), .i_data({i_wdata, i_wstrb}),
		.o_valid(wskd_valid), .i_ready(write_ready), .o_data({wskd_data, wskd_strb}));

	// Both halves present and B channel free
	assign write_ready = awskd_valid && wskd_valid && (!o_bvalid || i_bready);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = 2'b00;

	// Select register, zero-extended before the merge
	assign merged_word = apply_wstrb({{(AXIL_DATA_WIDTH-LG_STREAMS){1'b0}}, o_req_index},
		wskd_data, wskd_strb);

	// Status is read-only, writes there fall through
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_req_index <= '0;
		else if (write_ready && awskd_addr == REG_SELECT)
			o_req_index <= merged_word[LG_STREAMS-1:0];
	end

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	skid_buffer #(.DW(WADDR_W)) u_ar_skid (
		.i_clk(S_AXI_ACLK), .i_reset(S_AXI_ARESETN),
		.i_valid(i_arvalid), .o_ready(o_arready),
		.i_data(i_araddr[AXIL_ADDR_WIDTH-1:ADDR_LSB]),
		.o_valid(arskd_valid), .i_ready(read_ready), .o_data(arskd_addr));

	// R channel free or draining this cycle
	assign read_ready = arskd_valid && (!o_rvalid || i_rready);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (read_ready)
			o_rvalid <= 1'b1;
		else if (i_rready)
			o_rvalid <= 1'b0;
	end

	// Address decode
	always_comb
	begin
		read_word = '0;
		case (arskd_addr)
			REG_SELECT: read_word[LG_STREAMS-1:0] = o_req_index;
			REG_STATUS:
			begin
				read_word[LG_STREAMS-1:0] = i_active_index;
				read_word[STATUS_BUSY_BIT] = i_mid_packet;
			end
			default: read_word = '0;
		endcase
	end

	// Held until the next accepted read
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (read_ready)
			o_rdata <= read_word;
	end

	assign o_rresp = 2'b00;

endmodule

// File: src/skid_buffer.sv
// Valid/ready skid buffer with a registered upstream ready and pass-through when empty
module skid_buffer #(
	// Payload width
	parameter int DW = 8
) (
	input  logic          i_clk,
	// Synchronous, active low
	input  logic          i_reset,

	// Upstream side
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,

	// Downstream side
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	////////////////////////////////////////////////////////////
	// Overflow entry
	////////////////////////////////////////////////////////////

	// Set while a beat waits for downstream
	logic          r_valid;
	// Payload of the held beat
	logic [DW-1:0] r_data;

	// Ready from a register only, no path from i_ready
	assign o_ready = !r_valid;

	always_ff @(posedge i_clk)
	begin
		if (!i_reset)
			r_valid <= 1'b0;
		// Beat arrives while downstream stalls
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		// Held beat drained
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whenever empty, only kept if r_valid sets
	always_ff @(posedge i_clk)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	////////////////////////////////////////////////////////////
	// Output select
	////////////////////////////////////////////////////////////

	// Held beat goes first, otherwise straight through
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

// File: src/axis_switch_pkg.sv
// Shared widths, stream count and register map of the AXI-Stream packet switch
package axis_switch_pkg;

	////////////////////////////////////////////////////////////
	// AXI4-Lite control bus
	////////////////////////////////////////////////////////////

	// Byte address, two words of register space
	localparam int AXIL_ADDR_WIDTH = 3;
	localparam int AXIL_DATA_WIDTH = 32;
	localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;
	// Byte offset inside a word, dropped by the decoder
	localparam int ADDR_LSB = 2;

	////////////////////////////////////////////////////////////
	// Stream side
	////////////////////////////////////////////////////////////
	localparam int NUM_STREAMS = 4;
	localparam int LG_STREAMS = $clog2(NUM_STREAMS);
	localparam int AXIS_DATA_WIDTH = 32;

	// Word addresses of the two registers
	localparam logic [AXIL_ADDR_WIDTH-ADDR_LSB-1:0] REG_SELECT = 'd0;
	localparam logic [AXIL_ADDR_WIDTH-ADDR_LSB-1:0] REG_STATUS = 'd1;
	// Status word, packet in progress
	localparam int STATUS_BUSY_BIT = 8;

endpackage
